//--- common/BattleCatsPkg.sv
`default_nettype none

package BattleCatsPkg;

	//////////////////////////////
	// lane and fighter types
	//////////////////////////////

	typedef logic [8:0] PosT;
	typedef logic [7:0] HpT;
	typedef logic [1:0] KindT;
	typedef logic [7:0] DmgT;

	// enemy tower sits at the far end of the lane
	localparam PosT LaneEnd = 9'd400;
	localparam PosT Reach = 9'd10;
	localparam HpT TowerHp = 8'd200;

	// turn phases of the sequencer
	typedef enum logic [1:0] {
		PhaseIdle,
		PhaseScan,
		PhaseCombat,
		PhaseMove
	} PhaseT;

	typedef struct packed {
		HpT hp;
		DmgT attack;
		PosT speed;
	} StatT;

	// basic, tank, axe, runner
	function automatic StatT fighterStat(input KindT kind);
		case (kind)
			2'd0: return '{hp: 8'd20, attack: 8'd3, speed: 9'd4};
			2'd1: return '{hp: 8'd60, attack: 8'd1, speed: 9'd2};
			2'd2: return '{hp: 8'd30, attack: 8'd6, speed: 9'd3};
			default: return '{hp: 8'd12, attack: 8'd2, speed: 9'd8};
		endcase
	endfunction

	// health never wraps below zero
	function automatic HpT satSub(input HpT hp, input DmgT dmg);
		return (dmg >= hp) ? '0 : hp - dmg;
	endfunction

endpackage

`default_nettype wire

//--- common/DisplayPkg.sv
`default_nettype none

package DisplayPkg;

	typedef logic [3:0] NibbleT;

	// active low, abcdefg then Dp
	typedef logic [7:0] SegT;

	function automatic SegT segPattern(input NibbleT nibble);
		logic [6:0] abcdefg;
		case (nibble)
			4'h0: abcdefg = 7'b0000001;
			4'h1: abcdefg = 7'b1001111;
			4'h2: abcdefg = 7'b0010010;
			4'h3: abcdefg = 7'b0000110;
			4'h4: abcdefg = 7'b1001100;
			4'h5: abcdefg = 7'b0100100;
			4'h6: abcdefg = 7'b0100000;
			4'h7: abcdefg = 7'b0001111;
			4'h8: abcdefg = 7'b0000000;
			4'h9: abcdefg = 7'b0000100;
			4'hA: abcdefg = 7'b0001000;
			4'hB: abcdefg = 7'b1100000;
			4'hC: abcdefg = 7'b0110001;
			4'hD: abcdefg = 7'b1000010;
			4'hE: abcdefg = 7'b0110000;
			default: abcdefg = 7'b0111000;
		endcase
		// decimal point stays dark
		return {abcdefg, 1'b1};
	endfunction

endpackage

`default_nettype wire

//--- src/TurnSequencer.sv
`default_nettype none

module TurnSequencer
	import BattleCatsPkg::*;
#(
	parameter int TickCycles = 2 ** 22
)(
	input wire ClkPort,
	input wire Reset,
	input wire frontDone,
	input wire gameOver,
	output logic frontStart,
	output logic combatEn,
	output logic moveEn
);

	localparam int CntW = $clog2(TickCycles);

	logic [CntW-1:0] tickCount;
	PhaseT phase;

	assign combatEn = (phase == PhaseCombat);
	assign moveEn = (phase == PhaseMove);

	//////////////////////////////
	// game tick
	//////////////////////////////

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
		begin
			tickCount <= '0;
			frontStart <= 1'b0;
		end
		else
		begin
			frontStart <= 1'b0;
			// frozen for good once a tower falls
			if (!gameOver)
			begin
				if (tickCount == CntW'(TickCycles - 1))
				begin
					tickCount <= '0;
					frontStart <= 1'b1;
				end
				else
					tickCount <= tickCount + 1'b1;
			end
		end
	end

	//////////////////////////////
	// turn phases
	//////////////////////////////

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
			phase <= PhaseIdle;
		else
		begin
			case (phase)
				PhaseIdle:   if (frontStart) phase <= PhaseScan;
				PhaseScan:   if (frontDone) phase <= PhaseCombat;
				PhaseCombat: phase <= PhaseMove;
				default:     phase <= PhaseIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- battle/BattleFront.sv
`default_nettype none

module BattleFront
	import BattleCatsPkg::*;
#(
	parameter int NumSlots = 16
)(
	input wire ClkPort,
	input wire Reset,
	input wire frontStart,
	input wire [NumSlots*$bits(PosT)-1:0] unitPos,
	input wire [NumSlots-1:0] unitAlive,
	input wire [NumSlots*$bits(PosT)-1:0] enemyPos,
	input wire [NumSlots-1:0] enemyAlive,
	output PosT unitFront,
	output PosT enemyFront,
	output logic [$clog2(NumSlots)-1:0] unitTarget,
	output logic [$clog2(NumSlots)-1:0] enemyTarget,
	output logic unitsAlive,
	output logic enemiesAlive,
	output logic frontDone
);

	localparam int IdxW = $clog2(NumSlots);
	localparam int PosW = $bits(PosT);

	logic busy;
	logic [IdxW-1:0] idx;

	// running extremes over the slots seen so far
	PosT runUnitFront, nextUnitFront, runEnemyFront, nextEnemyFront;
	logic [IdxW-1:0] runUnitSlot, nextUnitSlot, runEnemySlot, nextEnemySlot;
	logic runUnitAny, nextUnitAny, runEnemyAny, nextEnemyAny;
	PosT slotUnitPos, slotEnemyPos;

	assign frontDone = busy && (idx == IdxW'(NumSlots - 1));

	always_comb
	begin
		slotUnitPos = unitPos[idx*PosW +: PosW];
		slotEnemyPos = enemyPos[idx*PosW +: PosW];
		{nextUnitFront, nextUnitSlot, nextUnitAny} = {runUnitFront, runUnitSlot, runUnitAny};
		{nextEnemyFront, nextEnemySlot, nextEnemyAny} = {runEnemyFront, runEnemySlot, runEnemyAny};
		// strict compare keeps the lowest slot on a tie
		if (unitAlive[idx] && (!runUnitAny || slotUnitPos > runUnitFront))
			{nextUnitFront, nextUnitSlot, nextUnitAny} = {slotUnitPos, idx, 1'b1};
		if (enemyAlive[idx] && (!runEnemyAny || slotEnemyPos < runEnemyFront))
			{nextEnemyFront, nextEnemySlot, nextEnemyAny} = {slotEnemyPos, idx, 1'b1};
	end

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
		begin
			busy <= 1'b0;
			idx <= '0;
			{runUnitFront, runUnitSlot, runUnitAny} <= '0;
			{runEnemyFront, runEnemySlot, runEnemyAny} <= {LaneEnd, IdxW'(0), 1'b0};
			{unitFront, unitTarget, unitsAlive} <= '0;
			{enemyFront, enemyTarget, enemiesAlive} <= {LaneEnd, IdxW'(0), 1'b0};
		end
		else if (frontStart)
		begin
			busy <= 1'b1;
			idx <= '0;
			{runUnitFront, runUnitSlot, runUnitAny} <= '0;
			{runEnemyFront, runEnemySlot, runEnemyAny} <= {LaneEnd, IdxW'(0), 1'b0};
		end
		else if (busy)
		begin
			idx <= idx + 1'b1;
			{runUnitFront, runUnitSlot, runUnitAny} <= {nextUnitFront, nextUnitSlot, nextUnitAny};
			{runEnemyFront, runEnemySlot, runEnemyAny} <= {nextEnemyFront, nextEnemySlot, nextEnemyAny};
			if (frontDone)
			begin
				busy <= 1'b0;
				{unitFront, unitTarget, unitsAlive} <= {nextUnitFront, nextUnitSlot, nextUnitAny};
				{enemyFront, enemyTarget, enemiesAlive} <= {nextEnemyFront, nextEnemySlot, nextEnemyAny};
			end
		end
	end

endmodule

`default_nettype wire

//--- battle/DamageResolver.sv
`default_nettype none

module DamageResolver
	import BattleCatsPkg::*;
(
	input wire ClkPort,
	input wire Reset,
	input wire combatEn,
	input wire DmgT unitAttack,
	input wire DmgT enemyAttack,
	input wire unitsAlive,
	input wire enemiesAlive,
	output DmgT unitHitDamage,
	output DmgT enemyHitDamage,
	output HpT friendlyTowerHp,
	output HpT enemyTowerHp,
	output logic gameOver
);

	HpT friendlyTowerNext;
	HpT enemyTowerNext;

	//////////////////////////////
	// damage routing
	//////////////////////////////

	// with no defenders left the attack lands on the tower
	always_comb
	begin
		enemyHitDamage = enemiesAlive ? unitAttack : '0;
		unitHitDamage = unitsAlive ? enemyAttack : '0;

		if (enemiesAlive)
			enemyTowerNext = enemyTowerHp;
		else
			enemyTowerNext = satSub(enemyTowerHp, unitAttack);

		if (unitsAlive)
			friendlyTowerNext = friendlyTowerHp;
		else
			friendlyTowerNext = satSub(friendlyTowerHp, enemyAttack);
	end

	//////////////////////////////
	// tower state
	//////////////////////////////

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
		begin
			friendlyTowerHp <= TowerHp;
			enemyTowerHp <= TowerHp;
			gameOver <= 1'b0;
		end
		else if (combatEn)
		begin
			friendlyTowerHp <= friendlyTowerNext;
			enemyTowerHp <= enemyTowerNext;
			// sticky until reset
			if (friendlyTowerNext == '0 || enemyTowerNext == '0)
				gameOver <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- battle/FighterArray.sv
`default_nettype none

module FighterArray
	import BattleCatsPkg::*;
#(
	parameter int NumSlots = 16,
	parameter bit MarchUp = 1'b1
)(
	input wire ClkPort,
	input wire Reset,
	input wire spawn,
	input wire KindT spawnKind,
	input wire gameOver,
	input wire combatEn,
	input wire moveEn,
	input wire PosT oppFront,
	input wire [$clog2(NumSlots)-1:0] target,
	input wire DmgT hitDamage,
	output logic [NumSlots*$bits(PosT)-1:0] pos,
	output logic [NumSlots-1:0] alive,
	output DmgT attackSum
);

	localparam int IdxW = $clog2(NumSlots);
	localparam int PosW = $bits(PosT);

	PosT posReg [NumSlots];
	HpT hpReg [NumSlots];
	KindT kindReg [NumSlots];
	PosT stepPos [NumSlots];
	logic [NumSlots-1:0] engaged;
	StatT slotStat;
	StatT spawnStat;

	logic pending;
	KindT pendingKind;
	logic accept;
	logic anyFree;
	logic [IdxW-1:0] freeSlot;
	HpT hitHp;

	assign accept = spawn && !pending && !gameOver;
	assign hitHp = satSub(hpReg[target], hitDamage);
	assign spawnStat = fighterStat(pendingKind);

	//////////////////////////////
	// engagement, attack, step
	//////////////////////////////

	always_comb
	begin
		attackSum = '0;
		for (int i = 0; i < NumSlots; i++)
		begin
			slotStat = fighterStat(kindReg[i]);
			pos[i*PosW +: PosW] = posReg[i];
			if (MarchUp)
			begin
				engaged[i] = alive[i] && (posReg[i] + Reach >= oppFront);
				// never walk past the enemy front
				stepPos[i] = (posReg[i] + slotStat.speed >= oppFront) ? oppFront :
					posReg[i] + slotStat.speed;
			end
			else
			begin
				engaged[i] = alive[i] && (posReg[i] <= oppFront + Reach);
				stepPos[i] = (posReg[i] <= oppFront + slotStat.speed) ? oppFront :
					posReg[i] - slotStat.speed;
			end
			if (engaged[i])
				attackSum = attackSum + slotStat.attack;
		end
	end

	// lowest free slot wins
	always_comb
	begin
		anyFree = 1'b0;
		freeSlot = '0;
		for (int i = NumSlots - 1; i >= 0; i--)
		begin
			if (!alive[i])
			begin
				anyFree = 1'b1;
				freeSlot = IdxW'(i);
			end
		end
	end

	//////////////////////////////
	// slot state
	//////////////////////////////

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
		begin
			alive <= '0;
			pending <= 1'b0;
		end
		else
		begin
			if (accept)
				pending <= 1'b1;
			else if (moveEn)
				pending <= 1'b0;
			if (combatEn && alive[target] && hitHp == '0)
				alive[target] <= 1'b0;
			if (moveEn && pending && anyFree)
				alive[freeSlot] <= 1'b1;
		end
	end

	always_ff @(posedge ClkPort)
	begin
		if (accept)
			pendingKind <= spawnKind;
		if (combatEn && alive[target])
			hpReg[target] <= hitHp;
		if (moveEn)
		begin
			for (int i = 0; i < NumSlots; i++)
				if (alive[i] && !engaged[i])
					posReg[i] <= stepPos[i];
			// newcomer stands at its own tower this turn
			if (pending && anyFree)
			begin
				posReg[freeSlot] <= MarchUp ? PosT'(0) : LaneEnd;
				hpReg[freeSlot] <= spawnStat.hp;
				kindReg[freeSlot] <= pendingKind;
			end
		end
	end

endmodule

`default_nettype wire

//--- display/SegmentDisplay.sv
`default_nettype none

module SegmentDisplay
	import BattleCatsPkg::*;
	import DisplayPkg::*;
#(
	parameter int ScanBits = 18
)(
	input wire ClkPort,
	input wire Reset,
	input wire HpT friendlyTowerHp,
	input wire HpT enemyTowerHp,
	output logic [3:0] An,
	output SegT Cathodes
);

	logic [ScanBits+1:0] scanCount;
	logic [1:0] digit;
	NibbleT nibble;

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
			scanCount <= '0;
		else
			scanCount <= scanCount + 1'b1;
	end

	// top two bits pick the lit digit
	assign digit = scanCount[ScanBits+1 -: 2];

	always_comb
	begin
		An = 4'b1111;
		An[digit] = 1'b0;
		case (digit)
			2'd3: nibble = friendlyTowerHp[7:4];
			2'd2: nibble = friendlyTowerHp[3:0];
			2'd1: nibble = enemyTowerHp[7:4];
			default: nibble = enemyTowerHp[3:0];
		endcase
		Cathodes = segPattern(nibble);
	end

endmodule

`default_nettype wire

//--- src/BattleCatsTop.sv
`default_nettype none

module BattleCatsTop
	import BattleCatsPkg::*;
	import DisplayPkg::*;
#(
	parameter int NumSlots = 16,
	parameter int TickCycles = 2 ** 22,
	parameter int ScanBits = 18
)(
	input wire ClkPort,
	input wire Reset,
	input wire SpawnUnit,
	input wire SpawnEnemy,
	input wire KindT Kind,
	output logic [3:0] An,
	output SegT Cathodes,
	output logic GameOver
);

	localparam int IdxW = $clog2(NumSlots);
	localparam int PosW = $bits(PosT);

	logic frontStart;
	logic frontDone;
	logic combatEn;
	logic moveEn;

	logic [NumSlots*PosW-1:0] unitPos;
	logic [NumSlots*PosW-1:0] enemyPos;
	logic [NumSlots-1:0] unitAlive;
	logic [NumSlots-1:0] enemyAlive;

	PosT unitFront;
	PosT enemyFront;
	logic [IdxW-1:0] unitTarget;
	logic [IdxW-1:0] enemyTarget;
	logic unitsAlive;
	logic enemiesAlive;

	DmgT unitAttack;
	DmgT enemyAttack;
	DmgT unitHitDamage;
	DmgT enemyHitDamage;
	HpT friendlyTowerHp;
	HpT enemyTowerHp;

	TurnSequencer #(.TickCycles(TickCycles)) turnSeq0 (
		.ClkPort(ClkPort), .Reset(Reset), .frontDone(frontDone), .gameOver(GameOver),
		.frontStart(frontStart), .combatEn(combatEn), .moveEn(moveEn)
	);

	BattleFront #(.NumSlots(NumSlots)) front0 (
		.ClkPort(ClkPort), .Reset(Reset), .frontStart(frontStart),
		.unitPos(unitPos), .unitAlive(unitAlive), .enemyPos(enemyPos), .enemyAlive(enemyAlive),
		.unitFront(unitFront), .enemyFront(enemyFront),
		.unitTarget(unitTarget), .enemyTarget(enemyTarget),
		.unitsAlive(unitsAlive), .enemiesAlive(enemiesAlive), .frontDone(frontDone)
	);

	DamageResolver resolver0 (
		.ClkPort(ClkPort), .Reset(Reset), .combatEn(combatEn),
		.unitAttack(unitAttack), .enemyAttack(enemyAttack),
		.unitsAlive(unitsAlive), .enemiesAlive(enemiesAlive),
		.unitHitDamage(unitHitDamage), .enemyHitDamage(enemyHitDamage),
		.friendlyTowerHp(friendlyTowerHp), .enemyTowerHp(enemyTowerHp), .gameOver(GameOver)
	);

	// units march up from the friendly tower
	FighterArray #(.NumSlots(NumSlots), .MarchUp(1'b1)) unitSide0 (
		.ClkPort(ClkPort), .Reset(Reset), .spawn(SpawnUnit), .spawnKind(Kind),
		.gameOver(GameOver), .combatEn(combatEn), .moveEn(moveEn),
		.oppFront(enemyFront), .target(unitTarget), .hitDamage(unitHitDamage),
		.pos(unitPos), .alive(unitAlive), .attackSum(unitAttack)
	);

	FighterArray #(.NumSlots(NumSlots), .MarchUp(1'b0)) enemySide0 (
		.ClkPort(ClkPort), .Reset(Reset), .spawn(SpawnEnemy), .spawnKind(Kind),
		.gameOver(GameOver), .combatEn(combatEn), .moveEn(moveEn),
		.oppFront(unitFront), .target(enemyTarget), .hitDamage(enemyHitDamage),
		.pos(enemyPos), .alive(enemyAlive), .attackSum(enemyAttack)
	);

	SegmentDisplay #(.ScanBits(ScanBits)) display0 (
		.ClkPort(ClkPort), .Reset(Reset),
		.friendlyTowerHp(friendlyTowerHp), .enemyTowerHp(enemyTowerHp),
		.An(An), .Cathodes(Cathodes)
	);

endmodule

`default_nettype wire

//--- dv/BattleCats_assertions.sv
`default_nettype none

module TurnSequencerAssertions (
	input wire ClkPort,
	input wire Reset,
	input wire frontStart,
	input wire combatEn,
	input wire moveEn,
	input wire gameOver
);

	int overlapFails = 0;
	int orderFails = 0;
	int lateTickFails = 0;

	// tick, combat and move never share a cycle
	noOverlap: assert property (@(posedge ClkPort) disable iff (Reset)
		$onehot0({frontStart, combatEn, moveEn}))
	else
	begin
		overlapFails++;
		$error("frontStart, combatEn and moveEn are high in the same cycle");
	end

	// move comes exactly one cycle after combat, and only then
	moveAfterCombat: assert property (@(posedge ClkPort) disable iff (Reset)
		moveEn == $past(combatEn))
	else
	begin
		orderFails++;
		$error("moveEn does not follow combatEn by exactly one cycle");
	end

	noTickAfterEnd: assert property (@(posedge ClkPort) disable iff (Reset)
		frontStart |-> !gameOver)
	else
	begin
		lateTickFails++;
		$error("frontStart pulsed after game over");
	end

endmodule

bind TurnSequencer TurnSequencerAssertions seqChecks0 (
	.ClkPort(ClkPort), .Reset(Reset), .frontStart(frontStart),
	.combatEn(combatEn), .moveEn(moveEn), .gameOver(gameOver)
);

`default_nettype wire

//--- dv/BattleCatsTb.sv
`default_nettype none

module BattleCatsTb;

	localparam int NumSlots = 4;
	localparam int TickLen = 16;
	localparam int LaneEnd = 400;
	localparam int Reach = 10;
	localparam int RandomTurns = 500;
	localparam int EnemyTurns = 180;
	// both phases with thirty percent slack
	localparam int TimeoutCycles = (RandomTurns + EnemyTurns) * TickLen * 13 / 10;

	logic ClkPort = 1'b0;
	logic Reset = 1'b1;
	logic SpawnUnit = 1'b0;
	logic SpawnEnemy = 1'b0;
	logic [1:0] Kind = 2'd0;
	logic [3:0] An;
	logic [7:0] Cathodes;
	logic GameOver;

	// basic, tank, axe, runner
	int hpOf [4] = '{20, 60, 30, 12};
	int attackOf [4] = '{3, 1, 6, 2};
	int speedOf [4] = '{4, 2, 3, 8};

	// game model with side 0 for units and side 1 for enemies
	int mPos [2][NumSlots];
	int mHp [2][NumSlots];
	int mKind [2][NumSlots];
	bit mAlive [2][NumSlots];
	bit mPending [2];
	int mPendKind [2];
	int mTower [2];
	int mFront [2];
	bit mGameOver;
	int tickCnt;
	int turnStep;
	int scanCnt;

	int cycles = 0;
	int checks = 0;
	int errors = 0;

	BattleCatsTop #(.NumSlots(NumSlots), .TickCycles(TickLen), .ScanBits(2)) dut0 (
		.ClkPort(ClkPort), .Reset(Reset), .SpawnUnit(SpawnUnit), .SpawnEnemy(SpawnEnemy),
		.Kind(Kind), .An(An), .Cathodes(Cathodes), .GameOver(GameOver)
	);

	always #5 ClkPort = ~ClkPort;

	////////////////////////////////
	// model of the turn rules
	////////////////////////////////

	function automatic int afterHit(input int hp, input int dmg);
		return (dmg >= hp) ? 0 : hp - dmg;
	endfunction

	function automatic bit engagedAt(input int s, input int i);
		if (s == 0)
			return mAlive[0][i] && (mPos[0][i] + Reach >= mFront[1]);
		return mAlive[1][i] && (mPos[1][i] <= mFront[0] + Reach);
	endfunction

	task automatic resetModel();
		for (int s = 0; s < 2; s++)
		begin
			for (int i = 0; i < NumSlots; i++)
				mAlive[s][i] = 1'b0;
			mPending[s] = 1'b0;
			mTower[s] = 200;
		end
		mGameOver = 1'b0;
		tickCnt = 0;
		turnStep = 100;
		scanCnt = 0;
	endtask

	task automatic combatTurn();
		int target [2];
		bit any [2];
		int attack [2];
		for (int s = 0; s < 2; s++)
		begin
			any[s] = 1'b0;
			target[s] = 0;
			attack[s] = 0;
			mFront[s] = (s == 0) ? 0 : LaneEnd;
			// strict compare, so a tie keeps the lower slot
			for (int i = 0; i < NumSlots; i++)
			begin
				if (mAlive[s][i] && (!any[s] || (s == 0 && mPos[s][i] > mFront[s])
						|| (s == 1 && mPos[s][i] < mFront[s])))
				begin
					any[s] = 1'b1;
					target[s] = i;
					mFront[s] = mPos[s][i];
				end
			end
		end
		for (int s = 0; s < 2; s++)
			for (int i = 0; i < NumSlots; i++)
				if (engagedAt(s, i))
					attack[s] += attackOf[mKind[s][i]];
		// each side takes the other's attack on its front fighter, else on its tower
		for (int s = 0; s < 2; s++)
		begin
			if (any[s])
			begin
				mHp[s][target[s]] = afterHit(mHp[s][target[s]], attack[1 - s]);
				if (mHp[s][target[s]] == 0)
					mAlive[s][target[s]] = 1'b0;
			end
			else
				mTower[s] = afterHit(mTower[s], attack[1 - s]);
		end
		if (mTower[0] == 0 || mTower[1] == 0)
			mGameOver = 1'b1;
	endtask

	task automatic moveTurn();
		int step;
		int slot;
		for (int s = 0; s < 2; s++)
		begin
			for (int i = 0; i < NumSlots; i++)
			begin
				step = speedOf[mKind[s][i]];
				if (mAlive[s][i] && !engagedAt(s, i))
				begin
					if (s == 0)
						mPos[s][i] = (mPos[s][i] + step >= mFront[1]) ? mFront[1] :
							mPos[s][i] + step;
					else
						mPos[s][i] = (mPos[s][i] - step <= mFront[0]) ? mFront[0] :
							mPos[s][i] - step;
				end
			end
			slot = -1;
			for (int i = NumSlots - 1; i >= 0; i--)
				if (!mAlive[s][i])
					slot = i;
			if (mPending[s] && slot >= 0)
			begin
				mAlive[s][slot] = 1'b1;
				mPos[s][slot] = (s == 0) ? 0 : LaneEnd;
				mHp[s][slot] = hpOf[mPendKind[s]];
				mKind[s][slot] = mPendKind[s];
			end
		end
	endtask

	// one clock edge with all decisions on the state before it
	task automatic modelEdge();
		bit accept [2];
		bit overBefore;
		overBefore = mGameOver;
		accept[0] = SpawnUnit && !mPending[0] && !overBefore;
		accept[1] = SpawnEnemy && !mPending[1] && !overBefore;
		if (turnStep == 5)
			combatTurn();
		if (turnStep == 6)
			moveTurn();
		for (int s = 0; s < 2; s++)
		begin
			if (accept[s])
			begin
				mPending[s] = 1'b1;
				mPendKind[s] = int'(Kind);
			end
			else if (turnStep == 6)
				mPending[s] = 1'b0;
		end
		turnStep++;
		if (!overBefore)
		begin
			if (tickCnt == TickLen - 1)
			begin
				tickCnt = 0;
				turnStep = 0;
			end
			else
				tickCnt++;
		end
		scanCnt = (scanCnt + 1) % 16;
	endtask

	always @(posedge ClkPort)
	begin
		if (Reset)
			resetModel();
		else
			modelEdge();
	end

	////////////////////////////////
	// display checks
	////////////////////////////////

	// lit digit back from its active low abcdefg and Dp
	function automatic int segmentValue(input logic [7:0] seg);
		if (!seg[0])
			return -1;
		case (seg[7:1])
			7'b0000001: return 0;
			7'b1001111: return 1;
			7'b0010010: return 2;
			7'b0000110: return 3;
			7'b1001100: return 4;
			7'b0100100: return 5;
			7'b0100000: return 6;
			7'b0001111: return 7;
			7'b0000000: return 8;
			7'b0000100: return 9;
			7'b0001000: return 10;
			7'b1100000: return 11;
			7'b0110001: return 12;
			7'b1000010: return 13;
			7'b0110000: return 14;
			7'b0111000: return 15;
			default: return -1;
		endcase
	endfunction

	task automatic checkOutputs();
		int digit;
		int tower;
		int expNibble;
		logic [3:0] expAn;
		digit = scanCnt / 4;
		tower = (digit >= 2) ? mTower[0] : mTower[1];
		expNibble = (digit % 2 == 1) ? tower / 16 : tower % 16;
		expAn = 4'b1111 & ~(4'b0001 << digit);
		checks++;
		assert (An == expAn)
		else
		begin
			errors++;
			$display("MISMATCH at %0t: anodes %b, expected %b", $time, An, expAn);
		end
		assert (segmentValue(Cathodes) == expNibble)
		else
		begin
			errors++;
			$display("MISMATCH at %0t: digit %0d shows %0d, expected %0d", $time, digit,
				segmentValue(Cathodes), expNibble);
		end
		assert (GameOver == mGameOver)
		else
		begin
			errors++;
			$display("MISMATCH at %0t: GameOver %b, expected %b", $time, GameOver, mGameOver);
		end
	endtask

	task automatic applyReset();
		Reset = 1'b1;
		SpawnUnit = 1'b0;
		SpawnEnemy = 1'b0;
		Kind = 2'd0;
		repeat (8) @(negedge ClkPort);
		Reset = 1'b0;
	endtask

	always @(posedge ClkPort)
	begin
		cycles++;
		if (cycles >= TimeoutCycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial
	begin
		int seqFails;
		void'($urandom(17));
		applyReset();
		repeat (RandomTurns * TickLen)
		begin
			@(negedge ClkPort);
			checkOutputs();
			SpawnUnit = ($urandom % 8 == 0);
			SpawnEnemy = ($urandom % 8 == 0);
			Kind = 2'($urandom);
		end
		// fresh game of axes only with nothing to stop them
		applyReset();
		repeat (EnemyTurns * TickLen)
		begin
			@(negedge ClkPort);
			checkOutputs();
			SpawnEnemy = ($urandom % 8 == 0);
			Kind = 2'd2;
		end
		assert (GameOver)
		else
		begin
			errors++;
			$display("the enemy-only game never reached game over");
		end
		seqFails = dut0.turnSeq0.seqChecks0.overlapFails + dut0.turnSeq0.seqChecks0.orderFails
			+ dut0.turnSeq0.seqChecks0.lateTickFails;
		$display("checks: %0d, errors: %0d, sequencer assertion failures: %0d",
			checks, errors, seqFails);
		if (errors == 0 && seqFails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- BattleCats.f
common/BattleCatsPkg.sv
common/DisplayPkg.sv
src/TurnSequencer.sv
battle/BattleFront.sv
battle/DamageResolver.sv
battle/FighterArray.sv
display/SegmentDisplay.sv
src/BattleCatsTop.sv
dv/BattleCats_assertions.sv
dv/BattleCatsTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module BattleCatsTb -Mdir obj_dir -f BattleCats.f

out=$(./obj_dir/VBattleCatsTb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "TEST OK"
